// ==== mmio_top.f ====
hw/mmio_pkg.sv
hw/mmio_addr_decoder.sv
hw/mmio_ack_center.sv
hw/keypad_register.sv
hw/wb_manager.sv
hw/wb_sram.sv
hw/mmio_top.sv
dv/tb_mmio_top.sv

// ==== Bender.yml ====
package:
  name: mmio_top

sources:
  - hw/mmio_pkg.sv
  - hw/mmio_addr_decoder.sv
  - hw/mmio_ack_center.sv
  - hw/keypad_register.sv
  - hw/wb_manager.sv
  - hw/wb_sram.sv
  - hw/mmio_top.sv
  - target: test
    files:
      - dv/tb_mmio_top.sv

// ==== dv/tb_mmio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mmio_top;
    import mmio_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int ACK_TIMEOUT = 20;
    localparam int NUM_PAIRS   = 8;
    // Requests over all tests, plus a few for keypad strobes
    localparam int NUM_REQUESTS = 2 * NUM_PAIRS + 14;
    localparam int WATCHDOG_NS  = (NUM_REQUESTS * (ACK_TIMEOUT + 10) + 100) * CLK_PERIOD;
    // Address in the hole between RAM and the display, no region decodes it
    localparam addr_t IDLE_ADDR = 32'h0000_8000;

    logic                clk;
    logic                reset;
    addr_t               final_address;
    word_t               mem_store;
    logic                mem_read;
    logic                mem_write;
    logic                d_ack;
    logic                i_ack;
    word_t               instruction;
    word_t               memload;
    logic [BUTTON_W-1:0] button_pressed;
    logic [APP_W-1:0]    app;
    logic                rising;
    addr_t               display_address;
    word_t               display_data;
    logic                d_ack_display;
    logic                wen;

    // Reference copy of the SRAM contents
    word_t ref_mem [RAM_WORDS];
    int    errors;
    int    tests_passed;
    int    tests_failed;

    mmio_top uut (
        .clk               (clk),
        .reset             (reset),
        .final_address_i   (final_address),
        .mem_store_i       (mem_store),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .d_ack_o           (d_ack),
        .i_ack_o           (i_ack),
        .instruction_o     (instruction),
        .memload_o         (memload),
        .button_pressed_i  (button_pressed),
        .app_i             (app),
        .rising_i          (rising),
        .display_address_o (display_address),
        .display_data_o    (display_data),
        .d_ack_display_i   (d_ack_display),
        .wen_o             (wen)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_key(input key_code_t got, input key_code_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        if (cond !== 1'b1) begin
            $display("ERROR at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    function automatic addr_t ram_addr(input sram_index_t idx);
        return RAM_BASE + addr_t'({idx, 2'b00});
    endfunction

    // Holds one CPU request until its ack, keeps it hold cycles longer, then drops it
    task automatic run_request(input addr_t addr, input word_t data, input logic rd,
                               input logic wr, input logic fetch, input int hold,
                               output word_t load, output int latency, output int d_pulses);
        logic seen;
        int   n;
        seen     = 1'b0;
        latency  = -1;
        d_pulses = 0;
        load     = '0;
        n        = 0;
        @(posedge clk);
        final_address <= addr;
        mem_store     <= data;
        mem_read      <= rd;
        mem_write     <= wr;
        while (!seen && n < ACK_TIMEOUT) begin
            @(negedge clk);
            if (d_ack) d_pulses++;
            if (fetch ? i_ack : d_ack) begin
                seen    = 1'b1;
                latency = n;
                load    = fetch ? instruction : memload;
            end
            n++;
        end
        require(seen, $sformatf("the ack never arrived for address %h", addr));
        repeat (hold) begin
            @(negedge clk);
            if (d_ack) d_pulses++;
        end
        @(posedge clk);
        // A RAM address with no read or write is a fetch, so the address leaves RAM too
        final_address <= IDLE_ADDR;
        mem_read      <= 1'b0;
        mem_write     <= 1'b0;
        // Ack must be gone once the request drops
        @(negedge clk);
        if (d_ack) d_pulses++;
        @(posedge clk);
    endtask

    task automatic store_word(input sram_index_t idx, input word_t data);
        word_t load;
        int    lat;
        int    pulses;
        run_request(ram_addr(idx), data, 1'b0, 1'b1, 1'b0, 0, load, lat, pulses);
        require(lat == 3, "store ack did not arrive in cycle 3");
        require(pulses == 1, "store did not give exactly one d_ack_o pulse");
        ref_mem[idx] = data;
    endtask

    task automatic load_word(input sram_index_t idx, input string what);
        word_t load;
        int    lat;
        int    pulses;
        run_request(ram_addr(idx), $urandom, 1'b1, 1'b0, 1'b0, 0, load, lat, pulses);
        check_word(load, ref_mem[idx], what);
        require(lat == 3, "load ack did not arrive in cycle 3");
        require(pulses == 1, "load did not give exactly one d_ack_o pulse");
    endtask

    task automatic press_key(input logic [APP_W-1:0] a, input logic [BUTTON_W-1:0] b);
        @(posedge clk);
        app            <= a;
        button_pressed <= b;
        rising         <= 1'b1;
        @(posedge clk);
        rising <= 1'b0;
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            tests_passed++;
            $display("%-16s : pass", name);
        end else begin
            tests_failed++;
            $display("%-16s : %0d errors", name, errors - start);
        end
    endtask

    task automatic store_then_load();
        sram_index_t idx [NUM_PAIRS];
        int          start;
        start = errors;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            idx[i] = sram_index_t'($urandom);
            store_word(idx[i], $urandom);
        end
        for (int i = 0; i < NUM_PAIRS; i++) begin
            load_word(idx[i], "load after store");
        end
        report_test("store_then_load", start);
    endtask

    task automatic fetch_instruction();
        sram_index_t idx;
        word_t       load;
        int          lat;
        int          pulses;
        int          start;
        start = errors;
        idx   = sram_index_t'($urandom);
        store_word(idx, $urandom);
        run_request(ram_addr(idx), '0, 1'b0, 1'b0, 1'b1, 0, load, lat, pulses);
        check_word(load, ref_mem[idx], "fetched instruction");
        require(lat == 3, "fetch ack did not arrive in cycle 3");
        require(pulses == 0, "d_ack_o rose during a fetch");
        report_test("fetch", start);
    endtask

    task automatic read_keypad();
        logic [APP_W-1:0]    a;
        logic [BUTTON_W-1:0] b;
        key_code_t           exp;
        word_t               load;
        int                  lat;
        int                  pulses;
        int                  start;
        start = errors;
        // Second pass checks that a new strobe replaces the code
        for (int k = 0; k < 2; k++) begin
            a = APP_W'($urandom);
            b = BUTTON_W'($urandom);
            // A repeated code would hide a missed replacement
            if (k > 0 && {a, b} == exp) begin
                b = ~b;
            end
            exp = {a, b};
            press_key(a, b);
            run_request(KEYPAD_ADDR, '0, 1'b1, 1'b0, 1'b0, 0, load, lat, pulses);
            check_key(key_code_t'(load), exp, "keypad code");
            check_word(load, word_t'(exp), "zero-extended keypad word");
            require(lat == 3, "keypad ack did not arrive in cycle 3");
        end
        report_test("keypad", start);
    endtask

    task automatic write_display();
        sram_index_t idx;
        addr_t       addr;
        word_t       data;
        word_t       load;
        int          lat;
        int          pulses;
        int          start;
        start = errors;
        idx   = sram_index_t'($urandom);
        store_word(idx, $urandom);
        // Same low address bits as the RAM word, which must stay untouched
        addr = DISPLAY_BASE + addr_t'({idx, 2'b00});
        data = $urandom;
        fork
            run_request(addr, data, 1'b0, 1'b1, 1'b0, 0, load, lat, pulses);
            begin
                for (int n = 0; n < ACK_TIMEOUT && !wen; n++) @(negedge clk);
                if (!wen) begin
                    require(1'b0, "wen_o never rose for a display write");
                end else begin
                    check_word(display_address, addr, "display address");
                    check_word(display_data, data, "display data");
                    require(!d_ack, "d_ack_o rose before the display answered");
                    @(posedge clk);
                    d_ack_display <= 1'b1;
                    @(posedge clk);
                    d_ack_display <= 1'b0;
                end
            end
        join
        require(pulses == 1, "display write did not give exactly one d_ack_o pulse");
        load_word(idx, "RAM word behind a display write");
        report_test("display", start);
    endtask

    task automatic read_unmapped();
        addr_t addr;
        word_t load;
        int    lat;
        int    pulses;
        int    start;
        start = errors;
        // Word address in the hole between RAM and the display window
        addr = 32'h0000_1000 + addr_t'(($urandom % 32'h0000_D000) & ~32'h3);
        run_request(addr, '0, 1'b1, 1'b0, 1'b0, 0, load, lat, pulses);
        check_word(load, UNMAPPED_DATA, "unmapped read");
        require(lat == 0, "unmapped read did not ack in cycle 0");
        report_test("unmapped", start);
    endtask

    task automatic hold_write();
        sram_index_t idx;
        word_t       data;
        word_t       load;
        int          lat;
        int          pulses;
        int          start;
        start = errors;
        idx   = sram_index_t'($urandom);
        data  = $urandom;
        run_request(ram_addr(idx), data, 1'b0, 1'b1, 1'b0, 5, load, lat, pulses);
        ref_mem[idx] = data;
        require(pulses == 1, "held write did not give exactly one d_ack_o pulse");
        load_word(idx, "load after held write");
        report_test("held_request", start);
    endtask

    initial begin
        int unsigned seed;
        seed = 32'he097_713e;
        void'($urandom(seed));
        reset          = 1'b1;
        final_address  = IDLE_ADDR;
        mem_store      = '0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        button_pressed = '0;
        app            = '0;
        rising         = 1'b0;
        d_ack_display  = 1'b0;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        store_then_load();
        fetch_instruction();
        read_keypad();
        write_display();
        read_unmapped();
        hold_write();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired before the tests completed");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mmio_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_top (
    input  logic                          clk,
    input  logic                          reset,

    // CPU memory port
    input  mmio_pkg::addr_t               final_address_i,
    input  mmio_pkg::word_t               mem_store_i,
    input  logic                          mem_read_i,
    input  logic                          mem_write_i,
    output logic                          d_ack_o,
    output logic                          i_ack_o,
    output mmio_pkg::word_t               instruction_o,
    output mmio_pkg::word_t               memload_o,

    // Keypad
    input  logic [mmio_pkg::BUTTON_W-1:0] button_pressed_i,
    input  logic [mmio_pkg::APP_W-1:0]    app_i,
    input  logic                          rising_i,

    // Display window
    output mmio_pkg::addr_t               display_address_o,
    output mmio_pkg::word_t               display_data_o,
    input  logic                          d_ack_display_i,
    output logic                          wen_o
);
    import mmio_pkg::*;

    logic      ram_en;
    logic      key_en;
    logic      unmapped;
    logic      ram_done;
    logic      key_ack;
    logic      key_sel;
    logic      [3:0] key_dly;
    key_code_t key_code;
    word_t     ram_rdata;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;

    mmio_addr_decoder u_decoder (
        .address_i   (final_address_i),
        .mem_read_i  (mem_read_i),
        .mem_write_i (mem_write_i),
        .ram_en_o    (ram_en),
        .key_en_o    (key_en),
        .wen_o       (wen_o),
        .unmapped_o  (unmapped)
    );

    keypad_register u_keypad (
        .clk              (clk),
        .reset            (reset),
        .rising_i         (rising_i),
        .button_pressed_i (button_pressed_i),
        .app_i            (app_i),
        .key_code_o       (key_code)
    );

    // Fetches travel as reads on the bus
    wb_manager u_wb_manager (
        .clk         (clk),
        .reset       (reset),
        .read_req_i  (ram_en & ~mem_write_i),
        .write_req_i (ram_en & mem_write_i),
        .adr_i       (final_address_i),
        .dat_i       (mem_store_i),
        .wb_req_o    (wb_req),
        .wb_rsp_i    (wb_rsp),
        .dat_o       (ram_rdata),
        .done_o      (ram_done)
    );

    wb_sram u_sram (
        .clk      (clk),
        .reset    (reset),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    // Keypad enable delay line, ack lands three cycles after the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            key_dly <= '0;
        end else begin
            key_dly <= {key_dly[2:0], key_en};
        end
    end

    assign key_ack = key_dly[2] & ~key_dly[3];
    // Late stages only steer the mux during a live keypad read
    assign key_sel = key_en & (key_dly[1] | key_dly[2]);

    mmio_ack_center u_ack_center (
        .ram_done_i    (ram_done),
        .key_ack_i     (key_ack),
        .display_ack_i (d_ack_display_i),
        .ram_en_i      (ram_en),
        .wen_i         (wen_o),
        .unmapped_i    (unmapped),
        .mem_read_i    (mem_read_i),
        .mem_write_i   (mem_write_i),
        .d_ack_o       (d_ack_o),
        .i_ack_o       (i_ack_o)
    );

    always_comb begin
        if (key_sel) begin
            memload_o = word_t'(key_code);
        end else if (ram_en) begin
            memload_o = ram_rdata;
        end else begin
            memload_o = UNMAPPED_DATA;
        end
    end

    assign instruction_o     = memload_o;
    assign display_address_o = final_address_i;
    assign display_data_o    = mem_store_i;

endmodule

`default_nettype wire

// ==== hw/wb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_sram (
    input  logic              clk,
    input  logic              reset,
    input  mmio_pkg::wb_req_t wb_req_i,
    output mmio_pkg::wb_rsp_t wb_rsp_o
);
    import mmio_pkg::*;

    word_t       mem [RAM_WORDS];
    sram_index_t index;
    logic        access;
    logic        ack_q;
    word_t       rdat_q;

    assign index = wb_req_i.adr[11:2];

    // Drop a second strobe cycle while the ack is still out
    assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte lanes follow sel
    always_ff @(posedge clk) begin
        if (access && wb_req_i.we) begin
            for (int b = 0; b < 4; b++) begin
                if (wb_req_i.sel[b]) begin
                    mem[index][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !wb_req_i.we) begin
            rdat_q <= mem[index];
        end
    end

    always_comb begin
        wb_rsp_o.ack = ack_q;
        wb_rsp_o.dat = rdat_q;
    end

endmodule

`default_nettype wire

// ==== hw/wb_manager.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_manager (
    input  logic              clk,
    input  logic              reset,
    input  logic              read_req_i,
    input  logic              write_req_i,
    input  mmio_pkg::addr_t   adr_i,
    input  mmio_pkg::word_t   dat_i,
    output mmio_pkg::wb_req_t wb_req_o,
    input  mmio_pkg::wb_rsp_t wb_rsp_i,
    output mmio_pkg::word_t   dat_o,
    output logic              done_o
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        DONE,
        DRAIN
    } state_t;

    state_t state_q;
    state_t state_d;

    addr_t adr_q;
    word_t wdat_q;
    word_t rdat_q;
    logic  we_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (read_req_i || write_req_i) begin
                    state_d = BUS;
                end
            end
            BUS: begin
                if (wb_rsp_i.ack) begin
                    state_d = DONE;
                end
            end
            DONE: state_d = DRAIN;
            // Held requests must fall before another access starts
            DRAIN: begin
                if (!read_req_i && !write_req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request payload, captured when leaving IDLE
    always_ff @(posedge clk) begin
        if (state_q == IDLE && (read_req_i || write_req_i)) begin
            adr_q  <= adr_i;
            wdat_q <= dat_i;
            we_q   <= write_req_i;
        end
        if (state_q == BUS && wb_rsp_i.ack) begin
            rdat_q <= wb_rsp_i.dat;
        end
    end

    always_comb begin
        wb_req_o.cyc = state_q == BUS;
        wb_req_o.stb = state_q == BUS;
        wb_req_o.we  = we_q;
        wb_req_o.sel = 4'hF;
        wb_req_o.adr = adr_q;
        wb_req_o.dat = wdat_q;
    end

    assign dat_o  = rdat_q;
    assign done_o = state_q == DONE;

endmodule

`default_nettype wire

// ==== hw/keypad_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module keypad_register (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rising_i,
    input  logic [mmio_pkg::BUTTON_W-1:0] button_pressed_i,
    input  logic [mmio_pkg::APP_W-1:0]    app_i,
    output mmio_pkg::key_code_t           key_code_o
);
    import mmio_pkg::*;

    key_code_t key_code_q;
    key_code_t key_code_d;

    // App selector sits over the button number
    assign key_code_d = {app_i, button_pressed_i};

    // Latest key wins; held until the next strobe
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            key_code_q <= '0;
        end else if (rising_i) begin
            key_code_q <= key_code_d;
        end
    end

    assign key_code_o = key_code_q;

endmodule

`default_nettype wire

// ==== hw/mmio_ack_center.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_ack_center (
    input  logic ram_done_i,
    input  logic key_ack_i,
    input  logic display_ack_i,
    input  logic ram_en_i,
    input  logic wen_i,
    input  logic unmapped_i,
    input  logic mem_read_i,
    input  logic mem_write_i,
    output logic d_ack_o,
    output logic i_ack_o
);

    logic data_req;
    logic ram_data_ack;
    logic ram_fetch_ack;
    logic disp_ack;

    assign data_req = mem_read_i | mem_write_i;

    // RAM completion splits by request kind
    assign ram_data_ack  = ram_en_i & ram_done_i & data_req;
    assign ram_fetch_ack = ram_en_i & ram_done_i & ~data_req;

    // Display answers on its own pulse, only while a write is decoded
    assign disp_ack = wen_i & display_ack_i;

    always_comb begin
        d_ack_o = ram_data_ack | key_ack_i | disp_ack;
        // Unmapped data accesses complete at once
        if (unmapped_i) begin
            d_ack_o = 1'b1;
        end
        i_ack_o = ram_fetch_ack;
    end

endmodule

`default_nettype wire

// ==== hw/mmio_addr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mmio_addr_decoder (
    input  mmio_pkg::addr_t address_i,
    input  logic            mem_read_i,
    input  logic            mem_write_i,
    output logic            ram_en_o,
    output logic            key_en_o,
    output logic            wen_o,
    output logic            unmapped_o
);
    import mmio_pkg::*;

    logic in_ram;
    logic in_display;
    logic in_keypad;
    logic data_req;

    // Offset compares keep the window checks unsigned and base-relative
    assign in_ram     = (address_i - RAM_BASE) < RAM_SPAN;
    assign in_display = (address_i - DISPLAY_BASE) < DISPLAY_SPAN;
    assign in_keypad  = address_i == KEYPAD_ADDR;

    assign data_req = mem_read_i | mem_write_i;

    always_comb begin
        // A RAM request also covers fetches with no read or write
        ram_en_o = in_ram;
        key_en_o = in_keypad & mem_read_i & ~mem_write_i;
        wen_o    = in_display & mem_write_i;

        // Keypad writes and display reads land here too
        unmapped_o = data_req & ~ram_en_o & ~key_en_o & ~wen_o;
    end

endmodule

`default_nettype wire

// ==== hw/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

    // Data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Keypad code with the app selector above the button number
    localparam int BUTTON_W = 5;
    localparam int APP_W    = 2;
    typedef logic [APP_W+BUTTON_W-1:0] key_code_t;

    // Word index into the SRAM
    typedef logic [9:0] sram_index_t;

    // Memory map
    localparam addr_t RAM_BASE      = 32'h0000_0000;
    localparam int    RAM_WORDS     = 1024;
    localparam addr_t RAM_SPAN      = RAM_WORDS * 4;
    localparam addr_t DISPLAY_BASE  = 32'h0000_E000;
    localparam addr_t DISPLAY_SPAN  = 32'h0000_1000;
    localparam addr_t KEYPAD_ADDR   = 32'h0000_F000;
    localparam word_t UNMAPPED_DATA = 32'hDEAD_BEEF;

    // Wishbone manager to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] sel;
        addr_t      adr;
        word_t      dat;
    } wb_req_t;

    // Wishbone slave to manager
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
